/* Makefile */
TOP = layer_para_scale_fp16_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f sources.f \
		-Mdir obj_dir -o sim_top
	./obj_dir/sim_top > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/cnn_geom_pkg.sv */
package cnn_geom_pkg;

	// kernel geometry, one square kernel per slice
	localparam int kernel_size = 3;
	localparam int kernel_taps = kernel_size * kernel_size; // words per kernel

	// feature map limits
	localparam int fm_size_max = 8;    // largest edge
	localparam int fm_size_width = 4;  // holds fm_size_max
	localparam int fm_depth_max = 2;   // largest slice count
	localparam int fm_depth_width = 2; // holds fm_depth_max

	// pixel address is slice*64 + row*8 + col
	localparam int fm_addr_width = 7;

	// weight ram holds one kernel per slice
	localparam int weight_addr_width = 1;

	// layer type codes, pool and fc are not built
	localparam int layer_type_width = 2;
	localparam logic [layer_type_width-1:0] layer_load = 2'd0; // host fills the rams
	localparam logic [layer_type_width-1:0] layer_conv = 2'd1; // engine runs

endpackage

/* design/conv_engine.sv */
`timescale 1ns/10ps

module conv_engine (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic [cnn_geom_pkg::layer_type_width-1:0]     layer_type,
	input  logic [cnn_geom_pkg::fm_size_width-1:0]        fm_size,
	input  logic [cnn_geom_pkg::fm_depth_width-1:0]       fm_depth,
	input  logic                                          fm_ready,
	input  logic                                          weight_ready,
	output logic [cnn_geom_pkg::fm_addr_width-1:0]        fm_rd_addr,
	output logic [cnn_geom_pkg::weight_addr_width-1:0]    weight_rd_addr,
	input  fp16_pkg::pixel_t                              fm_rd_data,
	input  fp16_pkg::kernel_t                             weight_rd_data,
	output fp16_pkg::pixel_t                              mul_a,
	output fp16_pkg::pixel_t                              mul_b,
	output fp16_pkg::pixel_t                              add_b,  // accumulator operand
	input  fp16_pkg::pixel_t                              sum,
	output logic                                          out_valid,
	output fp16_pkg::pixel_t                              out_data,
	output logic                                          layer_ready
);

	localparam int ks = cnn_geom_pkg::kernel_size;
	localparam int pos_w = $clog2(cnn_geom_pkg::fm_size_max); // row or column
	localparam int tap_w = $clog2(cnn_geom_pkg::kernel_taps);

	logic running;  // terms being issued
	logic finished; // layer done, hold until layer type changes
	logic [cnn_geom_pkg::fm_size_width-1:0] size_q;
	logic [cnn_geom_pkg::fm_depth_width-1:0] depth_q;
	logic [pos_w-1:0] orow; // output pixel
	logic [pos_w-1:0] ocol;
	logic [cnn_geom_pkg::weight_addr_width-1:0] slice;
	logic [1:0] krow; // kernel tap
	logic [1:0] kcol;
	logic is_conv, start;
	logic kcol_last, krow_last, slice_last, ocol_last, orow_last;
	logic first_term, pix_last, layer_last;
	logic v1, first1, last1, end1; // address stage
	logic [tap_w-1:0] tap1;
	logic v2, first2, last2, end2; // ram data stage
	logic [tap_w-1:0] tap2;
	logic out_last;
	fp16_pkg::pixel_t acc;

	assign is_conv = layer_type == cnn_geom_pkg::layer_conv;
	assign start = is_conv && !running && !finished && fm_ready && weight_ready;

	assign kcol_last = kcol == 2'(ks - 1);
	assign krow_last = krow == 2'(ks - 1);
	assign slice_last = {1'b0, slice} == depth_q - 2'd1;
	assign ocol_last = {1'b0, ocol} == size_q - 4'(ks); // valid conv, no padding
	assign orow_last = {1'b0, orow} == size_q - 4'(ks);
	assign first_term = slice == '0 && krow == '0 && kcol == '0;
	assign pix_last = slice_last && krow_last && kcol_last;
	assign layer_last = pix_last && ocol_last && orow_last;

	// geometry sampled on the start edge
	always_ff @(posedge clk) begin
		if (start) begin
			size_q <= fm_size;
			depth_q <= fm_depth;
		end
	end

	// walk: output row, output col, slice, kernel row, kernel col
	always_ff @(posedge clk) begin
		if (reset || !is_conv) begin
			running <= 1'b0;
			finished <= 1'b0;
			orow <= '0;
			ocol <= '0;
			slice <= '0;
			krow <= '0;
			kcol <= '0;
		end else if (start) begin
			running <= 1'b1;
		end else if (running) begin
			if (!kcol_last) begin
				kcol <= kcol + 2'd1;
			end else begin
				kcol <= '0;
				if (!krow_last) begin
					krow <= krow + 2'd1;
				end else begin
					krow <= '0;
					if (!slice_last) begin
						slice <= slice + 1'b1;
					end else begin
						slice <= '0;
						if (!ocol_last) begin
							ocol <= ocol + 1'b1;
						end else begin
							ocol <= '0;
							if (!orow_last) begin
								orow <= orow + 1'b1;
							end else begin
								orow <= '0; // last term issued
								running <= 1'b0;
								finished <= 1'b1;
							end
						end
					end
				end
			end
		end
	end

	// read issue and data alignment, tap follows its pixel through the ram
	always_ff @(posedge clk) begin
		fm_rd_addr <= {slice, orow + pos_w'(krow), ocol + pos_w'(kcol)};
		weight_rd_addr <= slice; // one kernel per slice
		tap1 <= tap_w'(krow) * tap_w'(ks) + tap_w'(kcol);
		first1 <= first_term;
		last1 <= pix_last;
		end1 <= layer_last;
		tap2 <= tap1;
		first2 <= first1;
		last2 <= last1;
		end2 <= end1;
		if (v2)
			acc <= sum;
		if (v2 && last2) begin
			out_data <= sum; // final term of this pixel
			out_last <= end2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			out_valid <= 1'b0;
			layer_ready <= 1'b0;
		end else begin
			v1 <= running;
			v2 <= v1;
			out_valid <= v2 && last2;
			if (!is_conv)
				layer_ready <= 1'b0;
			else if (out_valid && out_last)
				layer_ready <= 1'b1; // cycle after the last result
		end
	end

	assign mul_a = fm_rd_data;
	assign mul_b = weight_rd_data[tap2];
	assign add_b = first2 ? fp16_pkg::fp16_zero : acc; // each pixel starts at +0

endmodule

/* design/fp16_add.sv */
`timescale 1ns/10ps

module fp16_add (
	input  fp16_pkg::pixel_t a,
	input  fp16_pkg::pixel_t b,
	output fp16_pkg::pixel_t s
);

	localparam int mw = fp16_pkg::man_width;
	localparam int ew = fp16_pkg::exp_width;
	localparam int xw = ew + 2; // signed exponent after renormalization

	logic [ew+mw-1:0] mag_a;
	logic [ew+mw-1:0] mag_b;
	logic [ew+mw-1:0] big_mag;
	logic [ew+mw-1:0] small_mag;
	logic big_sign;
	logic small_sign;
	logic [ew-1:0] exp_big;
	logic [ew-1:0] exp_small;
	logic [ew-1:0] diff;
	logic [mw:0] sig_big;
	logic [mw:0] sig_small;
	logic [mw:0] aligned;
	logic [mw+1:0] raw;     // one carry bit above the hidden one
	logic [mw+1:0] shifted;
	logic [3:0] lz;
	logic [mw-1:0] man_n;
	logic signed [xw-1:0] exp_n;

	always_comb begin
		// subnormals count as zero
		mag_a = (a[mw +: ew] == '0) ? '0 : a[ew+mw-1:0];
		mag_b = (b[mw +: ew] == '0) ? '0 : b[ew+mw-1:0];

		// larger magnitude first, its sign wins
		if (mag_b > mag_a) begin
			big_mag = mag_b;
			big_sign = b[ew+mw];
			small_mag = mag_a;
			small_sign = a[ew+mw];
		end else begin
			big_mag = mag_a;
			big_sign = a[ew+mw];
			small_mag = mag_b;
			small_sign = b[ew+mw];
		end

		exp_big = big_mag[mw +: ew];
		exp_small = small_mag[mw +: ew];
		sig_big = {exp_big != '0, big_mag[mw-1:0]};
		sig_small = {exp_small != '0, small_mag[mw-1:0]};
		diff = exp_big - exp_small;
		aligned = sig_small >> diff; // bits shifted out are dropped

		if (big_sign ^ small_sign)
			raw = {1'b0, sig_big} - {1'b0, aligned}; // never negative
		else
			raw = {1'b0, sig_big} + {1'b0, aligned};

		// leading zeros below the carry bit, highest set bit wins
		lz = '0;
		for (int i = 0; i <= mw; i++) begin
			if (raw[i])
				lz = 4'(mw - i);
		end
		shifted = raw << lz;

		if (raw[mw+1]) begin
			man_n = raw[mw:1]; // carry out, shift right and truncate
			exp_n = xw'(exp_big) + xw'(1);
		end else begin
			man_n = shifted[mw-1:0];
			exp_n = xw'(exp_big) - xw'(lz);
		end

		if (raw == '0)
			s = fp16_pkg::fp16_zero; // exact cancellation gives +0
		else if (exp_n <= 0)
			s = fp16_pkg::fp16_zero; // below normal range
		else if (exp_n >= fp16_pkg::exp_max)
			s = {big_sign, fp16_pkg::fp16_max[ew+mw-1:0]};
		else
			s = {big_sign, exp_n[ew-1:0], man_n};
	end

endmodule

/* design/fp16_mul.sv */
`timescale 1ns/10ps

module fp16_mul (
	input  fp16_pkg::pixel_t a,
	input  fp16_pkg::pixel_t b,
	output fp16_pkg::pixel_t p
);

	localparam int mw = fp16_pkg::man_width;
	localparam int ew = fp16_pkg::exp_width;
	localparam int xw = ew + 3; // room for the exponent sum and its sign

	logic [ew-1:0] ea;
	logic [ew-1:0] eb;
	logic [mw:0] sa; // significands with hidden one
	logic [mw:0] sb;
	logic [2*mw+1:0] prod;
	logic [mw-1:0] man_n;
	logic signed [xw-1:0] exp_n;
	logic sign;

	always_comb begin
		ea = a[mw +: ew];
		eb = b[mw +: ew];
		sa = {1'b1, a[mw-1:0]};
		sb = {1'b1, b[mw-1:0]};
		sign = a[ew+mw] ^ b[ew+mw];

		prod = sa * sb; // in [1,4) scaled by 2^20

		// one place of normalization when the product reaches 2
		exp_n = xw'(ea) + xw'(eb) - xw'(fp16_pkg::exp_bias) + xw'(prod[2*mw+1]);
		man_n = prod[2*mw+1] ? prod[2*mw:mw+1] : prod[2*mw-1:mw]; // truncate

		if (ea == '0 || eb == '0 || exp_n <= 0)
			p = fp16_pkg::fp16_zero; // zero or subnormal operand, underflow
		else if (exp_n >= fp16_pkg::exp_max)
			p = {sign, fp16_pkg::fp16_max[ew+mw-1:0]}; // overflow saturates
		else
			p = {sign, exp_n[ew-1:0], man_n};
	end

endmodule

/* design/fp16_pkg.sv */
package fp16_pkg;

	// ieee half precision layout
	localparam int data_width = 16;
	localparam int exp_width = 5;
	localparam int man_width = 10;
	localparam int exp_bias = 15;
	localparam int exp_max = 2 ** exp_width - 1; // all ones, inf/nan code, never produced

	typedef logic [data_width-1:0] pixel_t;

	localparam pixel_t fp16_max = 16'h7bff; // largest finite magnitude, saturation value
	localparam pixel_t fp16_zero = 16'h0000; // +0

	// tap 0 is kernel row 0 col 0, row-major, tap 0 in the low bits
	typedef pixel_t [cnn_geom_pkg::kernel_taps-1:0] kernel_t;

endpackage

/* design/layer_para_scale_fp16.sv */
`timescale 1ns/10ps

module layer_para_scale_fp16 (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic [cnn_geom_pkg::layer_type_width-1:0]     layer_type,
	input  logic [cnn_geom_pkg::fm_size_width-1:0]        fm_size,
	input  logic [cnn_geom_pkg::fm_depth_width-1:0]       fm_depth,
	input  logic                                          fm_wr,
	input  fp16_pkg::pixel_t                              init_fm_data,
	input  logic [cnn_geom_pkg::fm_addr_width-1:0]        write_fm_data_addr,
	input  logic                                          init_fm_data_done,
	input  logic                                          weight_wr,
	input  fp16_pkg::kernel_t                             weight_data,
	input  logic [cnn_geom_pkg::weight_addr_width-1:0]    write_weight_data_addr,
	input  logic                                          weight_data_done,
	output logic                                          init_fm_ram_ready,
	output logic                                          init_weight_ram_ready,
	output logic                                          out_valid,
	output fp16_pkg::pixel_t                              out_data,
	output logic                                          layer_ready
);

	localparam int pad_w = cnn_geom_pkg::fm_addr_width - cnn_geom_pkg::weight_addr_width;

	logic is_load;
	logic [cnn_geom_pkg::fm_addr_width-1:0] fm_rd_addr;
	logic [cnn_geom_pkg::weight_addr_width-1:0] weight_rd_addr;
	logic [cnn_geom_pkg::fm_addr_width-1:0] weight_wr_addr_ext;
	logic [cnn_geom_pkg::fm_addr_width-1:0] weight_rd_addr_ext;
	fp16_pkg::pixel_t fm_rd_data;
	fp16_pkg::kernel_t weight_rd_data;
	fp16_pkg::pixel_t mul_a, mul_b, product, add_b, sum;

	assign is_load = layer_type == cnn_geom_pkg::layer_load;
	assign weight_wr_addr_ext = {{pad_w{1'b0}}, write_weight_data_addr};
	assign weight_rd_addr_ext = {{pad_w{1'b0}}, weight_rd_addr};

	// done pulses turn into sticky ready flags
	always_ff @(posedge clk) begin
		if (reset) begin
			init_fm_ram_ready <= 1'b0;
			init_weight_ram_ready <= 1'b0;
		end else begin
			if (init_fm_data_done)
				init_fm_ram_ready <= 1'b1;
			if (weight_data_done)
				init_weight_ram_ready <= 1'b1;
		end
	end

	tile_ram #(.payload_t(fp16_pkg::pixel_t)) fm_ram (
		.clk(clk),
		.wr(fm_wr && is_load), // host writes only in the load layer
		.wr_addr(write_fm_data_addr),
		.wr_data(init_fm_data),
		.rd_addr(fm_rd_addr),
		.rd_data(fm_rd_data)
	);

	tile_ram #(.payload_t(fp16_pkg::kernel_t)) weight_ram (
		.clk(clk),
		.wr(weight_wr && is_load),
		.wr_addr(weight_wr_addr_ext),
		.wr_data(weight_data),
		.rd_addr(weight_rd_addr_ext),
		.rd_data(weight_rd_data)
	);

	fp16_mul u_mul (.a(mul_a), .b(mul_b), .p(product));

	fp16_add u_add (.a(product), .b(add_b), .s(sum)); // product plus running sum

	conv_engine u_engine (
		.clk(clk),
		.reset(reset),
		.layer_type(layer_type),
		.fm_size(fm_size),
		.fm_depth(fm_depth),
		.fm_ready(init_fm_ram_ready),
		.weight_ready(init_weight_ram_ready),
		.fm_rd_addr(fm_rd_addr),
		.weight_rd_addr(weight_rd_addr),
		.fm_rd_data(fm_rd_data),
		.weight_rd_data(weight_rd_data),
		.mul_a(mul_a),
		.mul_b(mul_b),
		.add_b(add_b),
		.sum(sum),
		.out_valid(out_valid),
		.out_data(out_data),
		.layer_ready(layer_ready)
	);

endmodule

/* design/tile_ram.sv */
`timescale 1ns/10ps

module tile_ram #(
	parameter type payload_t = fp16_pkg::pixel_t
) (
	input  logic                                   clk,
	input  logic                                   wr,
	input  logic [cnn_geom_pkg::fm_addr_width-1:0] wr_addr,
	input  payload_t                               wr_data,
	input  logic [cnn_geom_pkg::fm_addr_width-1:0] rd_addr,
	output payload_t                               rd_data
);

	// pixel words fill every slice, kernel words need one per slice
	localparam int fm_words = cnn_geom_pkg::fm_depth_max * cnn_geom_pkg::fm_size_max
		* cnn_geom_pkg::fm_size_max;
	localparam int words = ($bits(payload_t) > fp16_pkg::data_width) ?
		cnn_geom_pkg::fm_depth_max : fm_words;
	localparam int aw = $clog2(words); // low address bits actually decoded

	payload_t mem [words];

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_addr[aw-1:0]] <= wr_data;
		rd_data <= mem[rd_addr[aw-1:0]]; // old word on a same cycle write
	end

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic reset
);

	localparam real half_period = 2.0; // 4 ns clock
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// reset drops 1 ns after the last reset edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

/* sim/layer_para_scale_fp16_tb.sv */
`timescale 1ns/10ps

module layer_para_scale_fp16_tb;

	localparam int num_cases = 6;
	localparam int fill_pattern = 0; // arithmetic pattern, no negatives
	localparam int fill_random = 1;  // lfsr pixels, signed kernels
	localparam int fill_mirror = 2;  // slice 1 undoes slice 0
	localparam int drive_delay = 1;  // ns after the rising edge

	typedef struct {
		int fm_edge;
		int depth;
		int fill;
		int stray; // writes during conv that must be ignored
		int n_out; // (edge - 2) squared results
	} case_t;

	case_t cases [num_cases] = '{
		'{8, 1, fill_pattern, 0, 36},
		'{6, 2, fill_pattern, 1, 16},
		'{8, 2, fill_pattern, 0, 36},
		'{5, 1, fill_random, 0, 9},
		'{7, 2, fill_random, 1, 25},
		'{6, 2, fill_mirror, 0, 16}  // every result cancels to +0
	};

	logic clk;
	logic reset;
	logic [cnn_geom_pkg::layer_type_width-1:0] layer_type;
	logic [cnn_geom_pkg::fm_size_width-1:0] fm_size;
	logic [cnn_geom_pkg::fm_depth_width-1:0] fm_depth;
	logic fm_wr, init_fm_data_done, weight_wr, weight_data_done;
	fp16_pkg::pixel_t init_fm_data;
	logic [cnn_geom_pkg::fm_addr_width-1:0] write_fm_data_addr;
	fp16_pkg::kernel_t weight_data;
	logic [cnn_geom_pkg::weight_addr_width-1:0] write_weight_data_addr;
	logic init_fm_ram_ready, init_weight_ram_ready, out_valid, layer_ready;
	fp16_pkg::pixel_t out_data;

	int pix [cnn_geom_pkg::fm_depth_max][cnn_geom_pkg::fm_size_max][cnn_geom_pkg::fm_size_max];
	int ker [cnn_geom_pkg::fm_depth_max][cnn_geom_pkg::kernel_taps];
	int exp_q [$]; // expected integers of the current case, row-major
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic [15:0] lfsr_state = 16'd97;

	clock_gen clocks (.clk(clk), .reset(reset));

	layer_para_scale_fp16 uut (.*);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run passed %0d cycles before all cases finished", cycle_limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// galois lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int random_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | lfsr_state[0]; // bit shifted out this step
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// exact for magnitudes up to 2048
	function automatic logic [15:0] int_to_fp16(input int v);
		int mag;
		int e;
		logic [9:0] man;
		if (v == 0)
			return 16'h0000;
		mag = (v < 0) ? -v : v;
		e = 0;
		while ((mag >> (e + 1)) != 0)
			e++;
		if (e <= fp16_pkg::man_width)
			man = 10'((mag << (fp16_pkg::man_width - e)) & 'h3ff); // hidden one dropped
		else
			man = 10'((mag >> (e - fp16_pkg::man_width)) & 'h3ff);
		return {v < 0, 5'(e + fp16_pkg::exp_bias), man};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("** Error: %s is %h, expected %h at %0t ns", name, got, expected, $time);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic fill_case(input int k);
		int sz;
		sz = cases[k].fm_edge;
		for (int s = 0; s < cases[k].depth; s++) begin
			for (int r = 0; r < sz; r++) begin
				for (int c = 0; c < sz; c++) begin
					if (cases[k].fill == fill_pattern)
						pix[s][r][c] = (3 * s + 2 * r + c + r * c) % 5;
					else if (cases[k].fill == fill_mirror && s == 1)
						pix[s][r][c] = pix[0][r][c];
					else
						pix[s][r][c] = random_bits(3) % 5;
				end
			end
			for (int t = 0; t < cnn_geom_pkg::kernel_taps; t++) begin
				if (cases[k].fill == fill_pattern)
					ker[s][t] = (t + 2 * s + 1) % 5;
				else if (cases[k].fill == fill_mirror && s == 1)
					ker[s][t] = -ker[0][t]; // cancels slice 0 term for term
				else
					ker[s][t] = random_bits(4) % 9 - 4; // -4 to 4
			end
		end
	endtask

	// integer valid convolution, sum over slice, kernel row, kernel column
	task automatic model_case(input int k);
		int sz;
		int acc;
		int ks;
		sz = cases[k].fm_edge;
		ks = cnn_geom_pkg::kernel_size;
		exp_q.delete();
		for (int orow = 0; orow <= sz - ks; orow++) begin
			for (int ocol = 0; ocol <= sz - ks; ocol++) begin
				acc = 0;
				for (int s = 0; s < cases[k].depth; s++)
					for (int kr = 0; kr < ks; kr++)
						for (int kc = 0; kc < ks; kc++)
							acc += pix[s][orow + kr][ocol + kc] * ker[s][kr * ks + kc];
				exp_q.push_back(acc);
			end
		end
	endtask

	task automatic load_case(input int k);
		int sz;
		sz = cases[k].fm_edge;
		fm_size = 4'(sz);
		fm_depth = 2'(cases[k].depth);
		if (k > 0) begin
			check_value("init_fm_ram_ready", init_fm_ram_ready, 1); // sticky across layers
			check_value("init_weight_ram_ready", init_weight_ram_ready, 1);
		end
		for (int s = 0; s < cases[k].depth; s++) begin
			for (int r = 0; r < sz; r++) begin
				for (int c = 0; c < sz; c++) begin
					fm_wr = 1'b1;
					write_fm_data_addr = 7'(s * 64 + r * cnn_geom_pkg::fm_size_max + c);
					init_fm_data = int_to_fp16(pix[s][r][c]);
					next_cycle();
				end
			end
		end
		fm_wr = 1'b0;
		for (int s = 0; s < cases[k].depth; s++) begin
			weight_wr = 1'b1;
			write_weight_data_addr = 1'(s);
			for (int t = 0; t < cnn_geom_pkg::kernel_taps; t++)
				weight_data[t] = int_to_fp16(ker[s][t]); // tap 0 in the low word
			next_cycle();
		end
		weight_wr = 1'b0;
		if (k == 0) begin
			check_value("init_fm_ram_ready", init_fm_ram_ready, 0); // no done flag yet
			check_value("init_weight_ram_ready", init_weight_ram_ready, 0);
		end
		init_fm_data_done = 1'b1;
		next_cycle();
		init_fm_data_done = 1'b0;
		check_value("init_fm_ram_ready", init_fm_ram_ready, 1);
		if (k == 0)
			check_value("init_weight_ram_ready", init_weight_ram_ready, 0);
		weight_data_done = 1'b1;
		next_cycle();
		weight_data_done = 1'b0;
		check_value("init_weight_ram_ready", init_weight_ram_ready, 1);
	endtask

	task automatic run_case(input int k);
		int n_seen;
		int gap;
		int finished;
		n_seen = 0;
		gap = 0;
		finished = 0;
		layer_type = cnn_geom_pkg::layer_conv; // engine starts on the next edge
		if (cases[k].stray != 0) begin
			fm_wr = 1'b1;
			write_fm_data_addr = 7'd18; // slice 0 row 2 col 2
			init_fm_data = 16'h5000;
			weight_wr = 1'b1;
			write_weight_data_addr = '0;
			weight_data = {cnn_geom_pkg::kernel_taps{16'h4400}};
		end
		while (finished == 0) begin
			next_cycle();
			fm_wr = 1'b0;
			weight_wr = 1'b0;
			gap++;
			if (out_valid) begin
				if (n_seen < exp_q.size())
					check_value("out_data", out_data, int_to_fp16(exp_q[n_seen]));
				if (n_seen > 0) // one term per cycle
					check_value("out_valid_gap", gap, cases[k].depth * cnn_geom_pkg::kernel_taps);
				else // start edge, then 9 * depth + 2 cycles
					check_value("first_out_delay", gap,
						cases[k].depth * cnn_geom_pkg::kernel_taps + 3);
				check_value("layer_ready", layer_ready, 0);
				n_seen++;
				gap = 0;
			end else if (layer_ready) begin
				check_value("out_valid_count", n_seen, cases[k].n_out);
				check_value("layer_ready_delay", gap, 1);
				finished = 1;
			end
		end
		next_cycle();
		check_value("layer_ready", layer_ready, 1); // holds while still conv
		check_value("out_valid", out_valid, 0);
		layer_type = cnn_geom_pkg::layer_load;
		next_cycle();
		check_value("layer_ready", layer_ready, 0);
	endtask

	initial begin
		layer_type = cnn_geom_pkg::layer_load;
		fm_size = '0;
		fm_depth = '0;
		fm_wr = 1'b0;
		init_fm_data = '0;
		write_fm_data_addr = '0;
		init_fm_data_done = 1'b0;
		weight_wr = 1'b0;
		weight_data = '0;
		write_weight_data_addr = '0;
		weight_data_done = 1'b0;
		for (int k = 0; k < num_cases; k++)
			cycle_limit += cases[k].fm_edge * cases[k].fm_edge * cases[k].depth
				+ cases[k].n_out * 20;
		cycle_limit += 40;

		@(negedge reset);
		check_value("out_valid", out_valid, 0);
		check_value("layer_ready", layer_ready, 0);
		check_value("init_fm_ram_ready", init_fm_ram_ready, 0);
		check_value("init_weight_ram_ready", init_weight_ram_ready, 0);

		for (int k = 0; k < num_cases; k++) begin
			fill_case(k);
			model_case(k);
			load_case(k);
			run_case(k);
		end

		$display("%0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* sources.f */
design/cnn_geom_pkg.sv
design/fp16_pkg.sv
design/tile_ram.sv
design/fp16_mul.sv
design/fp16_add.sv
design/conv_engine.sv
design/layer_para_scale_fp16.sv
sim/clock_gen.sv
sim/layer_para_scale_fp16_tb.sv
